/* exec_cases.txt */
# columns: name unit op a b imm pc pred expected miss, all numbers in hex
# a/b are port_a/port_b, reg_a/reg_b or rs1/rs2; expected is result, correct_pc or load_data
add_wrap  alu 0 ffffffff 00000001 00000000 00000000 0 00000000 0
sub_neg   alu 1 00000000 00000001 00000000 00000000 0 ffffffff 0
sub_min   alu 1 80000000 00000001 00000000 00000000 0 7fffffff 0
and_mask  alu 2 ffffffff 0f0f0f0f 00000000 00000000 0 0f0f0f0f 0
or_mix    alu 3 f0000000 0000000f 00000000 00000000 0 f000000f 0
xor_ones  alu 4 ffffffff 12345678 00000000 00000000 0 edcba987 0
sll_0     alu 5 12345678 00000000 00000000 00000000 0 12345678 0
sll_31    alu 5 00000001 0000001f 00000000 00000000 0 80000000 0
srl_31    alu 6 80000000 0000001f 00000000 00000000 0 00000001 0
sra_31    alu 7 80000000 0000001f 00000000 00000000 0 ffffffff 0
slt_neg   alu 8 80000000 00000000 00000000 00000000 0 00000001 0
sltu_max  alu 9 00000000 ffffffff 00000000 00000000 0 00000001 0
beq_t     br  0 00000005 00000005 00000100 00001000 1 00001100 0
beq_n     br  0 00000005 00000006 00000100 00001000 1 00001004 1
bne_t     br  1 00000005 00000006 00000100 00001000 0 00001100 1
bne_n     br  1 00000007 00000007 00000100 00001000 0 00001004 0
blt_t     br  4 ffffffff 00000001 00000100 00001000 1 00001100 0
blt_n     br  4 00000001 ffffffff 00000100 00001000 1 00001004 1
bge_t     br  5 00000000 80000000 00000100 00001000 0 00001100 1
bge_n     br  5 80000000 00000000 00000100 00001000 0 00001004 0
bltu_t    br  6 00000001 ffffffff 00000100 00001000 0 00001100 1
bltu_n    br  6 ffffffff 00000001 00000100 00001000 0 00001004 0
bgeu_t    br  7 ffffffff ffffffff 00000100 00001000 1 00001100 0
bgeu_n    br  7 00000000 00000001 00000100 00001000 1 00001004 1
jal_back  br  2 00000000 00000000 fffffff0 00001000 1 00000ff0 0
jalr_odd  br  3 00002001 00000000 00000004 00001000 0 00002004 1
sw_40     ls  a 00000040 8899aabb 00000000 00000000 0 00000000 0
lw_40     ls  2 00000040 00000000 00000000 00000000 0 8899aabb 0
lb_41     ls  0 00000040 00000000 00000001 00000000 0 ffffffaa 0
lbu_43    ls  4 00000040 00000000 00000003 00000000 0 00000088 0
lh_42     ls  1 00000040 00000000 00000002 00000000 0 ffff8899 0
lhu_40    ls  5 00000040 00000000 00000000 00000000 0 0000aabb 0
sh_46     ls  9 00000040 0000c3d4 00000006 00000000 0 00000000 0
lh_46     ls  1 00000040 00000000 00000006 00000000 0 ffffc3d4 0
sb_45     ls  8 00000040 0000007f 00000005 00000000 0 00000000 0
lw_44     ls  2 00000040 00000000 00000004 00000000 0 c3d47f00 0
lw_neg    ls  2 00000050 00000000 fffffff0 00000000 0 8899aabb 0

/* vlog.f */
+incdir+.
exec_pkg.sv
fu_alu.sv
fu_branch.sv
fu_scalar_ls.sv
execute.sv
tb_execute.sv

/* run.sh */
#!/bin/sh
# build the execute stage testbench with verilator, run it, and grep the log for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f vlog.f --top-module tb_execute -o tb_execute \
    && ./obj_dir/tb_execute > sim.log 2>&1 \
    || { echo "build or simulation run failed"; exit 1; }
grep -q "PASS: all tests" sim.log \
    && echo "simulation passed" \
    || { cat sim.log; echo "simulation failed"; exit 1; }

/* tb_execute.sv */
// execute stage testbench with clock, reset, case file reader, data memory model and check task
`default_nettype none

`include "exec_params.svh"

module tb_execute import exec_pkg::*; ();

    logic               CLK;
    logic               arst_n;
    logic               halt_in;
    logic               spec_in;
    alu_req_t           alu_req;
    br_req_t            br_req;
    ls_req_t            ls_req;
    dmem_rsp_t          dmem_rsp = '0;
    logic               halt_out;
    logic               spec_out;
    alu_rsp_t           alu_rsp;
    br_rsp_t            br_rsp;
    ls_rsp_t            ls_rsp;
    dmem_req_t          dmem_req;
    logic [`NUM_FU-1:0] fu_done;
    logic               ls_busy;

    logic [31:0] mem [0:63];            // 64 words, byte address bits 7:2
    logic        pending;               // request seen, hit scheduled
    int          wait_left;
    int          hold_cycles;           // nonzero forces a slow memory
    integer      seed = 32'h87c6_dea6;
    int          errors;
    int          n_tests;

    execute dut0 (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // data memory, dhit after a random delay of 0 to 5 cycles
    always @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 64; i++) begin
                mem[i] <= '0;
            end
            dmem_rsp <= '0;
            pending  <= 1'b0;
        end else if (dmem_rsp.dhit || !(dmem_req.ren || dmem_req.wen)) begin
            dmem_rsp.dhit <= 1'b0;   // hit lasts one cycle
            pending       <= 1'b0;
        end else if (!pending) begin
            pending   <= 1'b1;
            wait_left <= (hold_cycles > 0) ? hold_cycles : $unsigned($random(seed)) % 6;
        end else if (wait_left > 0) begin
            wait_left <= wait_left - 1;
        end else begin
            dmem_rsp.dhit  <= 1'b1;
            dmem_rsp.rdata <= mem[dmem_req.addr[7:2]];   // old data, read before write
            for (int b = 0; b < 4; b++) begin
                if (dmem_req.wen && dmem_req.byte_en[b]) begin
                    mem[dmem_req.addr[7:2]][8*b +: 8] <= dmem_req.wdata[8*b +: 8];
                end
            end
        end
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR: %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic run_alu(input string name, input logic [3:0] op,
                           input logic [31:0] a, input logic [31:0] b, input logic [31:0] exp);
        @(posedge CLK);
        alu_req <= '{1'b1, alu_op_t'(op), a, b, 5'd1};
        @(posedge CLK);
        alu_req.enable <= 1'b0;
        @(negedge CLK);                                   // one cycle after enable
        check({name, " done"}, 32'd3, 32'({alu_rsp.done, fu_done[`FU_ALU]}));
        check({name, " result"}, exp, alu_rsp.result);
        check({name, " rd"}, 32'd1, 32'(alu_rsp.rd));
        @(negedge CLK);
        check({name, " done pulse"}, 32'd0, 32'(alu_rsp.done));
    endtask

    task automatic run_br(input string name, input logic [2:0] op, input logic [31:0] a,
                          input logic [31:0] b, input logic [31:0] imm, input logic [31:0] pc,
                          input logic pred, input logic [31:0] exp, input logic miss);
        @(posedge CLK);
        br_req <= '{1'b1, br_type_t'(op), a, b, pc, imm, pred, 5'd1};
        @(posedge CLK);
        br_req.enable <= 1'b0;
        @(negedge CLK);
        check({name, " resolved"}, 32'd3, 32'({br_rsp.resolved, fu_done[`FU_BR]}));
        check({name, " correct_pc"}, exp, br_rsp.correct_pc);
        check({name, " miss"}, 32'(miss), 32'(br_rsp.miss));
        check({name, " taken"}, 32'(miss ^ pred), 32'(br_rsp.taken));   // miss flips prediction
        check({name, " update_btb"}, 32'(miss ^ pred), 32'(br_rsp.update_btb));
        check({name, " target"}, (miss ^ pred) ? exp : pc + imm, br_rsp.target);
        check({name, " link"}, pc + `PC_STEP, br_rsp.link_wdat);
        check({name, " rd"}, 32'd1, 32'(br_rsp.rd));
        @(negedge CLK);
        check({name, " resolved pulse"}, 32'd0,
              32'({br_rsp.resolved, br_rsp.miss, br_rsp.update_btb}));
    endtask

    task automatic issue_ls(input logic [3:0] op, input logic [31:0] rs1,
                            input logic [31:0] rs2, input logic [31:0] imm);
        @(posedge CLK);
        ls_req <= '{1'b1, mem_type_t'(op), rs1, rs2, imm, 5'd2};
        @(posedge CLK);
        ls_req.enable <= 1'b0;
        @(negedge CLK);   // request now on dmem_req
    endtask

    task automatic wait_ls(input string name, input logic [31:0] exp);
        int n;
        for (n = 0; n < 50 && !ls_rsp.done; n++) begin
            @(negedge CLK);
        end
        if (!ls_rsp.done) begin
            $display("TIMEOUT: load/store unit did not finish case %s in 50 cycles", name);
            errors++;
        end else begin
            check({name, " data"}, exp, ls_rsp.load_data);
            check({name, " rd"}, 32'd2, 32'(ls_rsp.rd));
            check({name, " done/busy/ren/wen"}, 32'h8,
                  32'({fu_done[`FU_LS], ls_busy, dmem_req.ren, dmem_req.wen}));
        end
    endtask

    // slow lw at 0x40, alu op issued while it waits
    task automatic backpressure_test();
        int n;
        hold_cycles = 12;
        issue_ls(4'h2, 32'h40, 32'h0, 32'h0);
        for (n = 0; n < 50 && !ls_rsp.done; n++) begin
            check("bp addr", 32'h40, dmem_req.addr);
            check("bp ren/wen/be/busy", 32'h5f,
                  32'({dmem_req.ren, dmem_req.wen, dmem_req.byte_en, ls_busy}));
            @(posedge CLK);
            if (n == 2) alu_req <= '{1'b1, ALU_ADD, 32'd7, 32'd8, 5'd3};
            else alu_req.enable <= 1'b0;
            @(negedge CLK);
            if (n == 3) begin
                check("bp alu done", 32'd1, 32'(alu_rsp.done));
                check("bp alu result", 32'd15, alu_rsp.result);
                check("bp alu rd", 32'd3, 32'(alu_rsp.rd));
            end
        end
        hold_cycles = 0;
        wait_ls("bp load", 32'h8899_aabb);   // word left by the case file stores
    endtask

    task automatic flag_test();
        int n;
        for (n = 0; n < 4; n++) begin
            @(posedge CLK);
            halt_in <= n[0];
            spec_in <= n[1];
            @(negedge CLK);
            check("pass-through flags", 32'(n[1:0]), 32'({spec_out, halt_out}));
        end
    endtask

    initial begin
        string       name;
        string       unit;
        string       line;
        logic [31:0] op, a, b, imm, pc, pred, exp, miss;
        int          fd;
        int          code;
        errors      = 0;
        n_tests     = 0;
        hold_cycles = 0;
        arst_n  <= 1'b0;
        halt_in <= 1'b0;
        spec_in <= 1'b0;
        alu_req <= '0;
        br_req  <= '0;
        ls_req  <= '0;
        repeat (10) @(posedge CLK);
        arst_n <= 1'b1;
        @(negedge CLK);
        check("reset idle", 32'd0, 32'({fu_done, dmem_req.ren, dmem_req.wen, ls_busy,
                                         br_rsp.miss, br_rsp.update_btb}));
        flag_test();
        fd = $fopen("exec_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file exec_cases.txt");
            errors++;
        end else begin
            while ($fscanf(fd, "%s", name) == 1) begin
                if (name[0] == "#") begin
                    code = $fgets(line, fd);   // skip comment line
                end else begin
                    code = $fscanf(fd, "%s %h %h %h %h %h %h %h %h",
                                   unit, op, a, b, imm, pc, pred, exp, miss);
                    n_tests++;
                    if (code != 9) begin
                        $display("case %s has missing or unreadable fields", name);
                        errors++;
                    end else if (unit == "alu") begin
                        run_alu(name, op[3:0], a, b, exp);
                    end else if (unit == "br") begin
                        run_br(name, op[2:0], a, b, imm, pc, pred[0], exp, miss[0]);
                    end else if (unit == "ls") begin
                        issue_ls(op[3:0], a, b, imm);
                        check({name, " busy"}, 32'd1, 32'(ls_busy));
                        wait_ls(name, exp);
                    end else begin
                        $display("case %s names unknown unit %s", name, unit);
                        errors++;
                    end
                end
            end
            $fclose(fd);
            backpressure_test();
        end
        $display("cases run: %0d, errors: %0d", n_tests, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* execute.sv */
// execute stage top with alu, branch and scalar load/store units, flags and done vector
`default_nettype none

`include "exec_params.svh"

module execute import exec_pkg::*; (
    input  logic              CLK,
    input  logic              arst_n,

    // from scoreboard
    input  logic              halt_in,
    input  logic              spec_in,    // op issued under speculation
    input  alu_req_t          alu_req,
    input  br_req_t           br_req,
    input  ls_req_t           ls_req,

    // from data memory
    input  dmem_rsp_t         dmem_rsp,

    // pass-through flags
    output logic              halt_out,   // to mem
    output logic              spec_out,   // to wb

    // unit results
    output alu_rsp_t          alu_rsp,    // to wb
    output br_rsp_t           br_rsp,     // to fetch, sb, wb
    output ls_rsp_t           ls_rsp,     // to wb

    // to data memory
    output dmem_req_t         dmem_req,

    // to scoreboard
    output logic [`NUM_FU-1:0] fu_done,
    output logic              ls_busy     // blocks ls issue
);

    // flags ride through untouched
    assign halt_out = halt_in;
    assign spec_out = spec_in;

    // scalar alu, fixed one cycle
    fu_alu u_alu (
        .CLK    (CLK),
        .arst_n (arst_n),
        .req    (alu_req),
        .rsp    (alu_rsp)
    );

    // branch unit, fixed one cycle
    fu_branch u_branch (
        .CLK    (CLK),
        .arst_n (arst_n),
        .req    (br_req),
        .rsp    (br_rsp)
    );

    // scalar load/store, latency set by memory
    fu_scalar_ls u_sls (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .req      (ls_req),
        .dmem_rsp (dmem_rsp),
        .dmem_req (dmem_req),
        .rsp      (ls_rsp),
        .busy     (ls_busy)
    );

    // done vector, one bit per unit
    assign fu_done[`FU_ALU] = alu_rsp.done;
    assign fu_done[`FU_LS]  = ls_rsp.done;      // after dhit
    assign fu_done[`FU_BR]  = br_rsp.resolved;  // miss rides with resolved

endmodule

`default_nettype wire

/* fu_scalar_ls.sv */
// scalar load/store sequencer with request hold, byte lanes and load extension
`default_nettype none

`include "exec_params.svh"

module fu_scalar_ls import exec_pkg::*; (
    input  logic      CLK,
    input  logic      arst_n,
    input  ls_req_t   req,
    input  dmem_rsp_t dmem_rsp,
    output dmem_req_t dmem_req,
    output ls_rsp_t   rsp,
    output logic      busy
);

    typedef enum logic {
        LS_IDLE,
        LS_WAIT   // request held until dhit
    } ls_state_t;

    ls_state_t          state_q;
    logic [`XLEN-1:0]   eaddr;
    logic [`XLEN/8-1:0] be_d;
    logic [`XLEN-1:0]   addr_q;
    logic [`XLEN/8-1:0] be_q;
    logic [`XLEN-1:0]   wdata_q;
    mem_type_t          type_q;
    logic [`REG_W-1:0]  rd_q;
    logic               is_store;
    logic [`XLEN-1:0]   lane;      // addressed byte moved to bit 0
    logic [`XLEN-1:0]   load_d;
    logic [`XLEN-1:0]   load_q;
    logic               done_q;

    assign eaddr = req.rs1 + req.imm;  // base + offset

    // byte enables by access size
    always_comb begin
        case (req.mem_type)
            MEM_LB, MEM_LBU, MEM_SB: be_d = 4'b0001 << eaddr[1:0];
            MEM_LH, MEM_LHU, MEM_SH: be_d = 4'b0011 << {eaddr[1], 1'b0};
            default:                 be_d = 4'b1111;
        endcase
    end

    always_ff @(posedge CLK, negedge arst_n) begin
        if (!arst_n) begin
            state_q <= LS_IDLE;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                LS_IDLE: if (req.enable) state_q <= LS_WAIT;
                LS_WAIT: begin
                    if (dmem_rsp.dhit) begin
                        state_q <= LS_IDLE;
                        done_q  <= 1'b1;   // one cycle pulse
                    end
                end
                default: state_q <= LS_IDLE;
            endcase
        end
    end

    // capture op at issue, load data at hit
    always_ff @(posedge CLK) begin
        if (state_q == LS_IDLE && req.enable) begin
            addr_q  <= eaddr;
            be_q    <= be_d;
            wdata_q <= req.rs2 << {eaddr[1:0], 3'b000};  // into byte lane
            type_q  <= req.mem_type;
            rd_q    <= req.rd;
        end
        if (state_q == LS_WAIT && dmem_rsp.dhit) begin
            load_q <= load_d;
        end
    end

    assign is_store = type_q[3];
    assign lane     = dmem_rsp.rdata >> {addr_q[1:0], 3'b000};

    // extend by type, stores give zero
    always_comb begin
        case (type_q)
            MEM_LB:  load_d = {{(`XLEN-8){lane[7]}}, lane[7:0]};
            MEM_LH:  load_d = {{(`XLEN-16){lane[15]}}, lane[15:0]};
            MEM_LW:  load_d = lane;
            MEM_LBU: load_d = {{(`XLEN-8){1'b0}}, lane[7:0]};
            MEM_LHU: load_d = {{(`XLEN-16){1'b0}}, lane[15:0]};
            default: load_d = '0;
        endcase
    end

    assign busy = (state_q == LS_WAIT);  // scoreboard holds issue

    assign dmem_req = '{addr: {addr_q[`XLEN-1:2], 2'b00},
                        ren: busy & ~is_store,
                        wen: busy & is_store,
                        byte_en: be_q,
                        wdata: wdata_q};

    assign rsp = '{done: done_q, rd: rd_q, load_data: load_q};

endmodule

`default_nettype wire

/* fu_branch.sv */
// registered branch resolution, miss detection and link value
`default_nettype none

`include "exec_params.svh"

module fu_branch import exec_pkg::*; (
    input  logic    CLK,
    input  logic    arst_n,
    input  br_req_t req,
    output br_rsp_t rsp
);

    localparam logic [`PC_W-1:0] PC_INC = `PC_STEP;

    logic              eq;
    logic              lt_s;
    logic              lt_u;
    logic              taken_d;
    logic [`XLEN-1:0]  jalr_sum;
    logic [`PC_W-1:0]  target_d;
    logic [`PC_W-1:0]  seq_pc;       // fall-through pc
    logic              resolved_q;
    logic              miss_q;
    logic              upd_btb_q;
    logic              taken_q;
    logic [`PC_W-1:0]  correct_q;
    logic [`PC_W-1:0]  target_q;
    logic [`PC_W-1:0]  link_q;
    logic [`REG_W-1:0] rd_q;

    // condition compares
    assign eq   = (req.reg_a == req.reg_b);
    assign lt_s = ($signed(req.reg_a) < $signed(req.reg_b));
    assign lt_u = (req.reg_a < req.reg_b);

    always_comb begin
        case (req.br_type)
            BR_BEQ:  taken_d = eq;
            BR_BNE:  taken_d = ~eq;
            BR_BLT:  taken_d = lt_s;
            BR_BGE:  taken_d = ~lt_s;
            BR_BLTU: taken_d = lt_u;
            BR_BGEU: taken_d = ~lt_u;
            default: taken_d = 1'b1;  // jal, jalr
        endcase
    end

    // target, jalr is register relative with bit 0 cleared
    assign jalr_sum = req.reg_a + req.imm;
    assign target_d = (req.br_type == BR_JALR) ? {jalr_sum[`PC_W-1:1], 1'b0}
                                               : req.current_pc + req.imm;
    assign seq_pc   = req.current_pc + PC_INC;

    always_ff @(posedge CLK, negedge arst_n) begin
        if (!arst_n) begin
            resolved_q <= 1'b0;
            miss_q     <= 1'b0;
            upd_btb_q  <= 1'b0;
        end else begin
            resolved_q <= req.enable;
            miss_q     <= req.enable & (taken_d != req.predicted_taken);
            upd_btb_q  <= req.enable & taken_d;  // train btb on taken only
        end
    end

    always_ff @(posedge CLK) begin
        taken_q   <= taken_d;
        target_q  <= target_d;
        correct_q <= taken_d ? target_d : seq_pc;
        link_q    <= seq_pc;  // rd gets return address
        rd_q      <= req.rd;
    end

    assign rsp = '{resolved: resolved_q, miss: miss_q, taken: taken_q,
                   correct_pc: correct_q, target: target_q, update_btb: upd_btb_q,
                   rd: rd_q, link_wdat: link_q};

endmodule

`default_nettype wire

/* fu_alu.sv */
// registered scalar alu with shift, compare and add/sub paths
`default_nettype none

`include "exec_params.svh"

module fu_alu import exec_pkg::*; (
    input  logic     CLK,
    input  logic     arst_n,
    input  alu_req_t req,
    output alu_rsp_t rsp
);

    logic              sub_sel;    // sub, slt and sltu all subtract
    logic [`XLEN-1:0]  b_inv;
    logic [`XLEN:0]    addsub;     // top bit is carry out
    logic              lt_s;
    logic              lt_u;
    logic [4:0]        shamt;
    logic [`XLEN-1:0]  res_d;
    logic [`XLEN-1:0]  res_q;
    logic [`REG_W-1:0] rd_q;
    logic              done_q;

    // add/sub path, one adder shared with compares
    assign sub_sel = (req.op != ALU_ADD);
    assign b_inv   = req.port_b ^ {`XLEN{sub_sel}};
    assign addsub  = {1'b0, req.port_a} + {1'b0, b_inv} + {{`XLEN{1'b0}}, sub_sel};

    // compare path
    assign lt_u = ~addsub[`XLEN];   // no carry out means borrow
    assign lt_s = (req.port_a[`XLEN-1] ^ req.port_b[`XLEN-1]) ? req.port_a[`XLEN-1]
                                                             : addsub[`XLEN-1];

    assign shamt = req.port_b[4:0];  // rv32 shifts use low five bits

    always_comb begin
        case (req.op)
            ALU_ADD,
            ALU_SUB:  res_d = addsub[`XLEN-1:0];
            ALU_AND:  res_d = req.port_a & req.port_b;
            ALU_OR:   res_d = req.port_a | req.port_b;
            ALU_XOR:  res_d = req.port_a ^ req.port_b;
            ALU_SLL:  res_d = req.port_a << shamt;
            ALU_SRL:  res_d = req.port_a >> shamt;
            ALU_SRA:  res_d = $signed(req.port_a) >>> shamt;  // sign fill
            ALU_SLT:  res_d = {{(`XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: res_d = {{(`XLEN-1){1'b0}}, lt_u};
            default:  res_d = '0;
        endcase
    end

    // done pulse follows the sampled enable
    always_ff @(posedge CLK, negedge arst_n) begin
        if (!arst_n) begin
            done_q <= 1'b0;
        end else begin
            done_q <= req.enable;
        end
    end

    always_ff @(posedge CLK) begin
        res_q <= res_d;
        rd_q  <= req.rd;
    end

    assign rsp = '{done: done_q, rd: rd_q, result: res_q};  // to wb

endmodule

`default_nettype wire

/* exec_pkg.sv */
// execute stage opcode enums and per-unit request/response structs
`default_nettype none

`include "exec_params.svh"

package exec_pkg;

    // scalar alu ops, scoreboard sends these already decoded
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_t;

    // conditional codes follow funct3, jumps fill the unused slots
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_JAL  = 3'b010,
        BR_JALR = 3'b011,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } br_type_t;

    // bit 3 marks a store, low bits are the funct3 size/sign code
    typedef enum logic [3:0] {
        MEM_LB  = 4'b0000,
        MEM_LH  = 4'b0001,
        MEM_LW  = 4'b0010,
        MEM_LBU = 4'b0100,
        MEM_LHU = 4'b0101,
        MEM_SB  = 4'b1000,
        MEM_SH  = 4'b1001,
        MEM_SW  = 4'b1010
    } mem_type_t;

    typedef struct packed {
        logic              enable;   // one cycle, one op
        alu_op_t           op;
        logic [`XLEN-1:0]  port_a;
        logic [`XLEN-1:0]  port_b;   // reg or imm, picked upstream
        logic [`REG_W-1:0] rd;
    } alu_req_t;

    typedef struct packed {
        logic              done;
        logic [`REG_W-1:0] rd;
        logic [`XLEN-1:0]  result;
    } alu_rsp_t;

    typedef struct packed {
        logic              enable;
        br_type_t          br_type;
        logic [`XLEN-1:0]  reg_a;
        logic [`XLEN-1:0]  reg_b;
        logic [`PC_W-1:0]  current_pc;
        logic [`XLEN-1:0]  imm;
        logic              predicted_taken;   // fetch prediction
        logic [`REG_W-1:0] rd;                // link register
    } br_req_t;

    typedef struct packed {
        logic              resolved;
        logic              miss;         // outcome != prediction
        logic              taken;
        logic [`PC_W-1:0]  correct_pc;   // redirect target for fetch
        logic [`PC_W-1:0]  target;
        logic              update_btb;
        logic [`REG_W-1:0] rd;
        logic [`PC_W-1:0]  link_wdat;    // pc + 4 for jal/jalr
    } br_rsp_t;

    typedef struct packed {
        logic              enable;
        mem_type_t         mem_type;
        logic [`XLEN-1:0]  rs1;   // base
        logic [`XLEN-1:0]  rs2;   // store data
        logic [`XLEN-1:0]  imm;
        logic [`REG_W-1:0] rd;
    } ls_req_t;

    typedef struct packed {
        logic [`XLEN-1:0]   addr;      // word aligned
        logic               ren;
        logic               wen;
        logic [`XLEN/8-1:0] byte_en;
        logic [`XLEN-1:0]   wdata;     // already in its byte lane
    } dmem_req_t;

    typedef struct packed {
        logic             dhit;    // one cycle, ends the request
        logic [`XLEN-1:0] rdata;   // valid with dhit
    } dmem_rsp_t;

    typedef struct packed {
        logic              done;
        logic [`REG_W-1:0] rd;
        logic [`XLEN-1:0]  load_data;   // zero for stores
    } ls_rsp_t;

endpackage

`default_nettype wire

/* exec_params.svh */
// width, pc step, functional unit count and done vector bit order macros
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// datapath
`define XLEN     32   // data and address width
`define PC_W     32   // program counter width
`define REG_W    5    // architectural register index
`define PC_STEP  4    // bytes per instruction, no compressed ops

// done vector toward scoreboard
`define NUM_FU   3    // alu, scalar ls, branch
`define FU_ALU   0    // scalar alu bit
`define FU_LS    1    // scalar load/store bit
`define FU_BR    2    // branch unit bit

`endif
